/* include/tmip_settings.svh */
`ifndef TMIP_SETTINGS_SVH
`define TMIP_SETTINGS_SVH

// image side as a power of two
`define TMIP_DIM 8

`define TMIP_PIXELS (`TMIP_DIM * `TMIP_DIM)

// signed pixel width
`define TMIP_PIX_W 16

// action list depth
`define TMIP_MAX_ACT 8

// 3x3 template taps
`define TMIP_TPL 9

`endif

/* logic/tmip_pkg.sv */
`include "tmip_settings.svh"

package tmip_pkg;

	typedef logic signed [`TMIP_PIX_W-1:0] pixel_t;

	typedef logic [$clog2(`TMIP_DIM)-1:0] coord_t;

	// row in upper bits, column in lower bits
	typedef logic [$clog2(`TMIP_PIXELS)-1:0] addr_t;

	typedef enum logic [1:0] {
		act_corr = 2'd0,
		act_none = 2'd1,
		act_flip = 2'd2,
		act_bright = 2'd3
	} action_t;

	// tap 0 is top left
	typedef pixel_t [`TMIP_TPL-1:0] template_t;

	typedef struct packed {
		addr_t addr;
		pixel_t value;
	} pix_wr_t;

	typedef struct packed {
		action_t [`TMIP_MAX_ACT-1:0] list;
		logic [3:0] count;
	} act_list_t;

	typedef struct packed {
		coord_t row;
		coord_t col;
		pixel_t value;
	} peak_t;

endpackage

/* logic/tmip_loader.sv */
`include "tmip_settings.svh"

module tmip_loader (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_valid_2,
	input tmip_pkg::pixel_t image,
	input tmip_pkg::pixel_t template,
	input tmip_pkg::action_t action,
	output tmip_pkg::pix_wr_t pix_wr,
	output logic pix_wr_en,
	output tmip_pkg::template_t tpl,
	output tmip_pkg::act_list_t acts,
	output logic start
);
	import tmip_pkg::*;

	addr_t pix_cnt;
	logic [3:0] tpl_cnt;
	logic in_valid_2_q;

	// raster address and template tap counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt <= '0;
			tpl_cnt <= '0;
			pix_wr_en <= 1'b0;
		end else begin
			pix_wr_en <= in_valid;
			if (in_valid) begin
				pix_cnt <= pix_cnt + 1'b1;
				if (tpl_cnt < 4'(`TMIP_TPL))
					tpl_cnt <= tpl_cnt + 4'd1;
			end else begin
				pix_cnt <= '0;
				tpl_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		pix_wr.addr <= pix_cnt;
		pix_wr.value <= image;
		if (in_valid && tpl_cnt < 4'(`TMIP_TPL))
			tpl[tpl_cnt] <= template;
	end

	// action list is emptied while a new image arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acts <= '0;
		end else if (in_valid) begin
			acts.count <= '0;
		end else if (in_valid_2 && acts.count < 4'(`TMIP_MAX_ACT)) begin
			acts.list[acts.count[2:0]] <= action;
			acts.count <= acts.count + 4'd1;
		end
	end

	// start on the falling edge of in_valid_2
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_2_q <= 1'b0;
			start <= 1'b0;
		end else begin
			in_valid_2_q <= in_valid_2;
			start <= in_valid_2_q && !in_valid_2;
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_valid && in_valid_2));

endmodule

/* logic/tmip_frame_engine.sv */
`include "tmip_settings.svh"

module tmip_frame_engine (
	input logic clk,
	input logic rst_n,
	input tmip_pkg::pix_wr_t pix_wr,
	input logic pix_wr_en,
	input tmip_pkg::template_t tpl,
	input tmip_pkg::act_list_t acts,
	input logic start,
	input tmip_pkg::addr_t rd_addr,
	output tmip_pkg::pixel_t rd_data,
	output logic frame_done
);
	import tmip_pkg::*;

	// ping-pong buffers where src holds the current frame
	pixel_t frame [2][`TMIP_PIXELS];
	logic src;

	logic busy;
	logic [2:0] act_idx;
	addr_t pix;
	coord_t row;
	coord_t col;
	coord_t mirror_col;
	action_t cur;
	logic step_last;
	logic acts_last;
	pixel_t corr_px;
	pixel_t next_px;

	assign {row, col} = pix;
	assign mirror_col = coord_t'(`TMIP_DIM - 1) - col;
	assign cur = acts.list[act_idx];

	// act_none occupies a single cycle
	assign step_last = (cur == act_none) || (pix == addr_t'(`TMIP_PIXELS - 1));
	assign acts_last = ({1'b0, act_idx} + 4'd1) == acts.count;

	assign rd_data = frame[src][rd_addr];

	// zero padded 3x3 correlation around the current pixel
	always_comb begin : corr_sum
		logic signed [2*`TMIP_PIX_W+3:0] acc;
		int r;
		int c;
		acc = '0;
		r = 0;
		c = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				r = int'(row) + dr;
				c = int'(col) + dc;
				if (r >= 0 && r < `TMIP_DIM && c >= 0 && c < `TMIP_DIM)
					acc = acc + tpl[(dr + 1) * 3 + dc + 1] * frame[src][r * `TMIP_DIM + c];
			end
		end
		// keep the low 16 bits
		corr_px = pixel_t'(acc);
	end

	always_comb begin
		case (cur)
			act_corr: next_px = corr_px;
			act_flip: next_px = frame[src][{row, mirror_col}];
			// floor halving, then offset
			act_bright: next_px = (frame[src][pix] >>> 1) + pixel_t'(50);
			default: next_px = frame[src][pix];
		endcase
	end

	always_ff @(posedge clk) begin
		if (pix_wr_en)
			frame[src][pix_wr.addr] <= pix_wr.value;
		if (busy && cur != act_none)
			frame[~src][pix] <= next_px;
	end

	// action sequencer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			src <= 1'b0;
			act_idx <= '0;
			pix <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				act_idx <= '0;
				pix <= '0;
			end else if (busy) begin
				if (step_last) begin
					pix <= '0;
					act_idx <= act_idx + 3'd1;
					if (cur != act_none)
						src <= ~src;
					if (acts_last) begin
						busy <= 1'b0;
						frame_done <= 1'b1;
					end
				end else begin
					pix <= pix + 1'b1;
				end
			end
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

	// the list must be complete by the time start is seen
	a_start_acts: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> acts.count != 4'd0);

endmodule

/* logic/tmip_peak_stream.sv */
`include "tmip_settings.svh"

module tmip_peak_stream (
	input logic clk,
	input logic rst_n,
	input logic frame_done,
	input tmip_pkg::pixel_t rd_data,
	output tmip_pkg::addr_t rd_addr,
	output logic out_valid,
	output tmip_pkg::coord_t out_x,
	output tmip_pkg::coord_t out_y,
	output tmip_pkg::pixel_t out_value
);
	import tmip_pkg::*;

	logic scanning;
	logic streaming;
	addr_t cnt;
	coord_t scan_row;
	coord_t scan_col;
	logic cnt_last;
	peak_t peak;

	assign rd_addr = cnt;
	assign {scan_row, scan_col} = cnt;
	assign cnt_last = cnt == addr_t'(`TMIP_PIXELS - 1);

	// pass control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scanning <= 1'b0;
			streaming <= 1'b0;
			cnt <= '0;
		end else if (frame_done) begin
			scanning <= 1'b1;
			streaming <= 1'b0;
			cnt <= '0;
		end else if (scanning || streaming) begin
			cnt <= cnt + 1'b1;
			if (cnt_last) begin
				cnt <= '0;
				scanning <= 1'b0;
				streaming <= scanning;
			end
		end
	end

	// first strictly greater pixel wins, so ties keep the earlier one
	always_ff @(posedge clk) begin
		if (scanning && (cnt == '0 || rd_data > peak.value)) begin
			peak.row <= scan_row;
			peak.col <= scan_col;
			peak.value <= rd_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_x <= '0;
			out_y <= '0;
			out_value <= '0;
		end else if (streaming) begin
			out_valid <= 1'b1;
			out_x <= peak.row;
			out_y <= peak.col;
			out_value <= rd_data;
		end else begin
			out_valid <= 1'b0;
			out_x <= '0;
			out_y <= '0;
			out_value <= '0;
		end
	end

	a_pos_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && $past(out_valid)) |-> ($stable(out_x) && $stable(out_y)));

endmodule

/* logic/tmip_top.sv */
module tmip_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_valid_2,
	input tmip_pkg::pixel_t image,
	input tmip_pkg::pixel_t template,
	input tmip_pkg::action_t action,
	output logic out_valid,
	output tmip_pkg::coord_t out_x,
	output tmip_pkg::coord_t out_y,
	output tmip_pkg::pixel_t out_value
);
	import tmip_pkg::*;

	pix_wr_t pix_wr;
	logic pix_wr_en;
	template_t tpl;
	act_list_t acts;
	logic start;
	logic frame_done;
	addr_t rd_addr;
	pixel_t rd_data;

	tmip_loader loader0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_valid_2(in_valid_2),
		.image(image),
		.template(template),
		.action(action),
		.pix_wr(pix_wr),
		.pix_wr_en(pix_wr_en),
		.tpl(tpl),
		.acts(acts),
		.start(start)
	);

	tmip_frame_engine engine0 (
		.clk(clk),
		.rst_n(rst_n),
		.pix_wr(pix_wr),
		.pix_wr_en(pix_wr_en),
		.tpl(tpl),
		.acts(acts),
		.start(start),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.frame_done(frame_done)
	);

	tmip_peak_stream stream0 (
		.clk(clk),
		.rst_n(rst_n),
		.frame_done(frame_done),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.out_valid(out_valid),
		.out_x(out_x),
		.out_y(out_y),
		.out_value(out_value)
	);

endmodule

/* tb/tmip_tb.sv */
`include "tmip_settings.svh"

module tmip_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import tmip_pkg::*;

	localparam int pixels = `TMIP_PIXELS;
	localparam int frames = 20;
	// load burst, action gap and list, then up to nine full passes
	localparam int frame_budget = (pixels + 16) + 9 * pixels;
	localparam int rise_limit = 9 * pixels + 16;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_valid_2;
	pixel_t image;
	pixel_t template;
	action_t action;
	logic out_valid;
	coord_t out_x;
	coord_t out_y;
	pixel_t out_value;

	logic [31:0] lcg_state;
	pixel_t img_px [pixels];
	pixel_t model_px [pixels];
	pixel_t tap [`TMIP_TPL];
	action_t act_q [$];
	int value_errors;
	int other_errors;

	tmip_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_valid_2(in_valid_2),
		.image(image),
		.template(template),
		.action(action),
		.out_valid(out_valid),
		.out_x(out_x),
		.out_y(out_y),
		.out_value(out_value)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] span;
		span = 32'(hi - lo + 1);
		return lo + int'((lcg_next() >> 8) % span);
	endfunction

	task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	// reference for one action on model_px
	task automatic apply_action(input action_t a);
		pixel_t nxt [pixels];
		int sum;
		int r2;
		int c2;
		for (int r = 0; r < `TMIP_DIM; r++) begin
			for (int c = 0; c < `TMIP_DIM; c++) begin
				case (a)
					act_corr: begin
						sum = 0;
						for (int dr = -1; dr <= 1; dr++) begin
							for (int dc = -1; dc <= 1; dc++) begin
								r2 = r + dr;
								c2 = c + dc;
								if (r2 >= 0 && r2 < `TMIP_DIM && c2 >= 0 && c2 < `TMIP_DIM)
									sum += int'(tap[(dr + 1) * 3 + dc + 1])
										* int'(model_px[r2 * `TMIP_DIM + c2]);
							end
						end
						nxt[r * `TMIP_DIM + c] = pixel_t'(sum);
					end
					act_flip: nxt[r * `TMIP_DIM + c] = model_px[r * `TMIP_DIM + `TMIP_DIM - 1 - c];
					act_bright: nxt[r * `TMIP_DIM + c] =
						pixel_t'((int'(model_px[r * `TMIP_DIM + c]) >>> 1) + 50);
					default: nxt[r * `TMIP_DIM + c] = model_px[r * `TMIP_DIM + c];
				endcase
			end
		end
		model_px = nxt;
	endtask

	// raster index of the first strictly greatest pixel
	function automatic int peak_index();
		int best;
		best = 0;
		for (int i = 1; i < pixels; i++)
			if (model_px[i] > model_px[best])
				best = i;
		return best;
	endfunction

	task automatic run_frame();
		int waited;
		int run;
		int best;
		for (int k = 0; k < pixels; k++) begin
			@(negedge clk);
			check_count("out_valid", 0, int'(out_valid));
			in_valid = 1'b1;
			image = img_px[k];
			if (k < `TMIP_TPL)
				template = tap[k];
			else
				template = pixel_t'(rand_range(-99, 99));
		end
		@(negedge clk);
		in_valid = 1'b0;
		image = '0;
		template = '0;
		@(negedge clk);
		foreach (act_q[i]) begin
			@(negedge clk);
			in_valid_2 = 1'b1;
			action = act_q[i];
		end
		@(negedge clk);
		in_valid_2 = 1'b0;
		model_px = img_px;
		foreach (act_q[i])
			apply_action(act_q[i]);
		best = peak_index();
		waited = 0;
		while (out_valid !== 1'b1 && waited < rise_limit) begin
			@(negedge clk);
			waited++;
		end
		if (out_valid !== 1'b1) begin
			other_errors++;
			$display("out_valid did not rise within %0d cycles of the action list", rise_limit);
			return;
		end
		run = 0;
		while (out_valid === 1'b1 && run < 2 * pixels) begin
			if (run < pixels) begin
				check_pixel("out_value", model_px[run], out_value);
				check_coord("out_x", coord_t'(best / `TMIP_DIM), out_x);
				check_coord("out_y", coord_t'(best % `TMIP_DIM), out_y);
			end
			run++;
			@(negedge clk);
		end
		check_count("out_valid burst length", pixels, run);
	endtask

	initial begin : watchdog
		repeat (2 * frames * frame_budget) @(posedge clk);
		other_errors++;
		$display("watchdog expired after %0d cycles, the run did not finish",
			2 * frames * frame_budget);
		$display("tests failed");
		$finish;
	end

	initial begin
		int n;
		lcg_state = 32'h3fb4;
		value_errors = 0;
		other_errors = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_valid_2 = 1'b0;
		image = '0;
		template = '0;
		action = act_corr;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_count("out_valid", 0, int'(out_valid));
		check_coord("out_x", '0, out_x);
		check_coord("out_y", '0, out_y);
		check_pixel("out_value", '0, out_value);
		rst_n = 1'b1;
		for (int f = 0; f < frames; f++) begin
			for (int i = 0; i < pixels; i++)
				img_px[i] = pixel_t'(rand_range(-128, 127));
			for (int i = 0; i < `TMIP_TPL; i++)
				tap[i] = pixel_t'(rand_range(-8, 7));
			act_q.delete();
			case (f)
				0: act_q.push_back(act_corr);
				1: act_q.push_back(act_flip);
				2: begin
					// negative odd values round toward minus infinity
					img_px[0] = -16'sd7;
					img_px[1] = -16'sd1;
					act_q.push_back(act_bright);
				end
				3: begin
					img_px[10] = 16'sd500;
					img_px[20] = 16'sd500;
					img_px[45] = 16'sd500;
					act_q.push_back(act_flip);
				end
				default: begin
					n = rand_range(1, `TMIP_MAX_ACT);
					repeat (n) act_q.push_back(action_t'(rand_range(0, 3)));
				end
			endcase
			run_frame();
		end
		repeat (3) begin
			@(negedge clk);
			check_count("out_valid", 0, int'(out_valid));
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* tmip.f */
+incdir+include
logic/tmip_pkg.sv
logic/tmip_loader.sv
logic/tmip_frame_engine.sv
logic/tmip_peak_stream.sv
logic/tmip_top.sv
tb/tmip_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tmip_tb
FILELIST := tmip.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
